// File: bank_cfg_pkg.sv
package bank_cfg_pkg;

    // Number of envelope voices running side by side in the bank
    localparam int NUM_VOICES = 4;

    // Bits needed to name one voice
    localparam int VOICE_IDX_W = 2;

    // Width of the envelope accumulator
    // All step, level and duration settings share this width
    localparam int ACC_W = 32;

    // Each voice presents the top ENV_W bits of its accumulator as its gain
    localparam int ENV_W = 16;

    // Two guard bits hold the sum of four voices before saturation
    localparam int MIX_W = ENV_W + 2;

endpackage : bank_cfg_pkg

// File: envelope_pkg.sv
package envelope_pkg;

    import bank_cfg_pkg::*;

    // Shape of one envelope
    // Steps are added or removed once per clock in their phase
    typedef struct packed {
        // Amount added per cycle while rising
        logic [ACC_W-1:0] attack_step;
        // Amount removed per cycle while falling toward sustain
        logic [ACC_W-1:0] decay_step;
        // Amount removed per cycle while falling toward zero
        logic [ACC_W-1:0] release_step;
        // The hold lasts this many cycles plus one
        logic [ACC_W-1:0] sustain_duration;
        // Peak reached at the end of the attack
        logic [ACC_W-1:0] attack_level;
        // Level held during the sustain phase
        logic [ACC_W-1:0] sustain_level;
    } adsr_params_t;

    // Everything that travels with a note strobe
    // Only the envelope shape for now, pitch or velocity would sit next to it
    typedef struct packed {
        adsr_params_t params;
    } note_event_t;

    // Phases of one envelope voice
    typedef enum logic [2:0] {
        IDLE,
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } adsr_state_t;

endpackage : envelope_pkg

// File: adsr_envelope.sv
`timescale 1ns/10ps

module adsr_envelope
    import bank_cfg_pkg::*;
    import envelope_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,

    // Global enable, low parks the voice in IDLE
    input  logic             enable_i,

    // One-cycle pulse that launches a new envelope
    input  logic             start_i,

    // Envelope shape, held stable by the dispatcher for the whole note
    input  adsr_params_t     params_i,

    // High while no envelope is running
    output logic             idle_o,

    // Gain curve, the upper bits of the accumulator
    output logic [ENV_W-1:0] env_o
);

    // Current phase and its next value
    adsr_state_t state_q;
    adsr_state_t state_d;

    // Envelope accumulator, the fraction below ENV_W gives fine step sizes
    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_d;

    // Cycles spent in SUSTAIN so far
    logic [ACC_W-1:0] sus_cnt_q;
    logic [ACC_W-1:0] sus_cnt_d;

    // Accumulator and sustain counter
    // A start pulse always begins the curve from zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q     <= '0;
            sus_cnt_q <= '0;
        end else if (start_i) begin
            acc_q     <= '0;
            sus_cnt_q <= '0;
        end else begin
            acc_q     <= acc_d;
            sus_cnt_q <= sus_cnt_d;
        end
    end

    // Phase register
    // Dropping the enable sends the voice home without touching the accumulator
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else if (!enable_i) begin
            state_q <= IDLE;
        end else if (start_i) begin
            state_q <= ATTACK;
        end else begin
            state_q <= state_d;
        end
    end

    // Next phase and next accumulator value
    always_comb begin
        // By default everything holds its value
        state_d   = state_q;
        acc_d     = acc_q;
        sus_cnt_d = sus_cnt_q;

        case (state_q)
            // Nothing moves until a start pulse arrives
            IDLE: begin
                acc_d = acc_q;
            end

            ATTACK: begin
                // Climb one step per cycle
                acc_d = acc_q + params_i.attack_step;

                // Once the peak is reached, pin it there and start the decay
                if (acc_q >= params_i.attack_level) begin
                    acc_d   = params_i.attack_level;
                    state_d = DECAY;
                end
            end

            DECAY: begin
                // Fall toward the sustain level
                acc_d = acc_q - params_i.decay_step;

                // Land exactly on the sustain level and restart the hold timer
                if (acc_q <= params_i.sustain_level) begin
                    acc_d     = params_i.sustain_level;
                    sus_cnt_d = '0;
                    state_d   = SUSTAIN;
                end
            end

            SUSTAIN: begin
                // The level stays put while the timer runs
                sus_cnt_d = sus_cnt_q + 1'b1;

                // The compare includes zero, so the hold is duration plus one cycles
                if (sus_cnt_q == params_i.sustain_duration) begin
                    state_d = RELEASE;
                end
            end

            RELEASE: begin
                // Fade out toward silence
                acc_d = acc_q - params_i.release_step;

                // A last step larger than what remains would wrap below zero
                // so the accumulator is cleared directly instead
                if (acc_q <= params_i.release_step) begin
                    acc_d   = '0;
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign idle_o = (state_q == IDLE);

    // Upper half of the accumulator is the audible gain
    assign env_o = acc_q[ACC_W-1 -: ENV_W];

    // The dispatcher must keep the settings frozen while the voice holds its level
    a_sustain_level_held : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (state_q == SUSTAIN) |-> (acc_q == params_i.sustain_level)
    ) else $error("adsr_envelope: accumulator left the sustain level during SUSTAIN");

    // The dispatcher only hands notes to idle voices
    a_start_only_when_idle : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        start_i |-> (state_q == IDLE)
    ) else $error("adsr_envelope: start pulse reached a busy voice");

endmodule : adsr_envelope

// File: voice_dispatcher.sv
`timescale 1ns/10ps

module voice_dispatcher
    import bank_cfg_pkg::*;
    import envelope_pkg::*;
(
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,

    // Incoming note strobe and its settings
    input  logic                                    note_valid_i,
    input  note_event_t                             note_i,

    // Idle flags from every voice
    input  logic         [NUM_VOICES-1:0]           voices_idle_i,

    // Registered start pulse for at most one voice per cycle
    output logic         [NUM_VOICES-1:0]           voice_start_o,

    // Settings held for each voice until it is given a new note
    output adsr_params_t [NUM_VOICES-1:0]           voice_params_o,

    // Pulse for a note that found every voice busy
    output logic                                    note_dropped_o
);

    // Voice started on the previous cycle
    // Its idle flag only falls one edge later, so it must be skipped now
    logic [NUM_VOICES-1:0] start_q;

    // Drop pulse register
    logic drop_q;

    // One settings register per voice
    adsr_params_t [NUM_VOICES-1:0] params_q;

    // Voices able to take a note in this cycle
    logic [NUM_VOICES-1:0] free_voices;

    // Lowest free voice and whether one exists
    logic [VOICE_IDX_W-1:0] pick_idx;
    logic                   pick_found;

    assign free_voices = voices_idle_i & ~start_q;
    assign pick_found  = |free_voices;

    // Priority search
    // Scanning downward lets the lowest free voice overwrite the rest
    always_comb begin
        pick_idx = '0;
        for (int v = NUM_VOICES - 1; v >= 0; v--) begin
            if (free_voices[v]) begin
                pick_idx = VOICE_IDX_W'(v);
            end
        end
    end

    // Start and drop pulses last exactly one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q <= '0;
            drop_q  <= 1'b0;
        end else begin
            start_q <= '0;
            drop_q  <= note_valid_i && !pick_found;
            if (note_valid_i && pick_found) begin
                start_q[pick_idx] <= 1'b1;
            end
        end
    end

    // Settings are captured on the same edge that raises the start pulse
    always_ff @(posedge clk_i) begin
        if (note_valid_i && pick_found) begin
            params_q[pick_idx] <= note_i.params;
        end
    end

    assign voice_start_o  = start_q;
    assign voice_params_o = params_q;
    assign note_dropped_o = drop_q;

    // Back-to-back notes must land on different voices
    a_start_new_voice : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (voice_start_o & $past(voice_start_o)) == '0
    ) else $error("voice_dispatcher: same voice started on two cycles in a row");

    // A note is only dropped when at most the voice just started was still idle
    a_drop_only_when_full : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        note_dropped_o |-> ($countones($past(voices_idle_i)) <= 1)
    ) else $error("voice_dispatcher: note dropped while voices were free");

endmodule : voice_dispatcher

// File: envelope_mixer.sv
`timescale 1ns/10ps

module envelope_mixer
    import bank_cfg_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              arst_n_i,

    // Gain curves of all voices
    input  logic [NUM_VOICES-1:0][ENV_W-1:0]  env_i,

    // Idle flags of all voices
    input  logic [NUM_VOICES-1:0]             voices_idle_i,

    // Registered, saturated mix of the voices
    output logic [ENV_W-1:0]                  mix_o,

    // High when no voice is running
    output logic                              all_idle_o
);

    // Full-width sum and its clipped version
    logic [MIX_W-1:0] sum_wide;
    logic [ENV_W-1:0] sum_sat;

    // Output register
    logic [ENV_W-1:0] mix_q;

    // Add every voice with enough headroom that nothing is lost
    always_comb begin
        sum_wide = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            sum_wide = sum_wide + MIX_W'(env_i[v]);
        end
    end

    // Any bit above the output range means the mix clips at full scale
    always_comb begin
        if (|sum_wide[MIX_W-1:ENV_W]) begin
            sum_sat = '1;
        end else begin
            sum_sat = sum_wide[ENV_W-1:0];
        end
    end

    // One register stage between the voices and the output
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mix_q <= '0;
        end else begin
            mix_q <= sum_sat;
        end
    end

    assign mix_o = mix_q;

    // Bank-wide idle flag straight from the voices
    assign all_idle_o = &voices_idle_i;

    // Without saturation a wrapped sum could fall below the loudest voice
    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_mix_bound
        a_mix_covers_voice : assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            mix_o >= $past(env_i[v])
        ) else $error("envelope_mixer: mix fell below voice %0d", v);
    end

endmodule : envelope_mixer

// File: envelope_bank_top.sv
`timescale 1ns/10ps

module envelope_bank_top
    import bank_cfg_pkg::*;
    import envelope_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // Global enable for every voice
    input  logic                  enable_i,

    // Note strobe with its envelope settings
    input  logic                  note_valid_i,
    input  note_event_t           note_i,

    // Mixed gain curve
    output logic [ENV_W-1:0]      mix_o,

    // Per-voice and bank-wide idle status
    output logic [NUM_VOICES-1:0] voices_idle_o,
    output logic                  all_idle_o,

    // Pulse for every note that found no free voice
    output logic                  note_dropped_o
);

    // Dispatcher to voices
    logic         [NUM_VOICES-1:0]            voice_start;
    adsr_params_t [NUM_VOICES-1:0]            voice_params;

    // Voices back to the dispatcher and the mixer
    logic         [NUM_VOICES-1:0]            voice_idle;
    logic         [NUM_VOICES-1:0][ENV_W-1:0] voice_env;

    voice_dispatcher u_voice_dispatcher (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .note_valid_i   (note_valid_i),
        .note_i         (note_i),
        .voices_idle_i  (voice_idle),
        .voice_start_o  (voice_start),
        .voice_params_o (voice_params),
        .note_dropped_o (note_dropped_o)
    );

    // One envelope generator per voice
    for (genvar k = 0; k < NUM_VOICES; k++) begin : g_voice
        adsr_envelope u_adsr_envelope (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .enable_i (enable_i),
            .start_i  (voice_start[k]),
            .params_i (voice_params[k]),
            .idle_o   (voice_idle[k]),
            .env_o    (voice_env[k])
        );
    end

    envelope_mixer u_envelope_mixer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .env_i         (voice_env),
        .voices_idle_i (voice_idle),
        .mix_o         (mix_o),
        .all_idle_o    (all_idle_o)
    );

    assign voices_idle_o = voice_idle;

endmodule : envelope_bank_top

// File: tb_envelope_bank.sv
`timescale 1ns/10ps

module tb_envelope_bank
    import bank_cfg_pkg::*;
    import envelope_pkg::*;
();

    // One row of the stimulus table
    typedef struct packed {
        logic [3:0]   n_notes;
        adsr_params_t params;
        logic         enable;
        logic [15:0]  exp_peak;
        logic [3:0]   exp_idle;
        logic [3:0]   exp_drops;
    } test_row_t;

    logic        clk_i;
    logic        arst_n_i;
    logic        enable_i;
    logic        note_valid_i;
    note_event_t note_i;

    logic [ENV_W-1:0]      mix_o;
    logic [NUM_VOICES-1:0] voices_idle_o;
    logic                  all_idle_o;
    logic                  note_dropped_o;

    test_row_t rows[$];
    string     names[$];

    integer seed = 32'h75b4aab8;

    // Run-wide cycle budget that grows as rows are added
    int cycle_count = 0;
    int cycle_limit = 0;

    // Per-row observations and bookkeeping
    int          row_steps;
    int          row_errors;
    logic [15:0] peak_seen;
    int          drops_seen;
    int          pass_count = 0;
    int          fail_count = 0;

    envelope_bank_top u_envelope_bank_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .enable_i       (enable_i),
        .note_valid_i   (note_valid_i),
        .note_i         (note_i),
        .mix_o          (mix_o),
        .voices_idle_o  (voices_idle_o),
        .all_idle_o     (all_idle_o),
        .note_dropped_o (note_dropped_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Compares one observed value with its expected value
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual %h expected %h", name, actual, expected);
            row_errors++;
        end
    endtask

    // Advances one clock and samples the outputs 1 ns after the edge
    // Every pulse on note_dropped_o lasts one cycle, so each is seen exactly once
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
        cycle_count++;
        row_steps++;
        if (mix_o > peak_seen) begin
            peak_seen = mix_o;
        end
        if (note_dropped_o) begin
            drops_seen++;
        end
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the envelopes did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    endtask

    // Builds one table row with random power-of-two step sizes
    // Levels have zero low halves, so a shift of 2 to 5 always divides them exactly
    task automatic add_row(input string name, input int n, input logic [15:0] atk_top,
                           input logic [15:0] sus_top, input int dur, input logic en,
                           input logic [3:0] exp_idle, input int exp_drops);
        test_row_t row;
        int        sa;
        int        sd;
        int        sr;
        int        nv;
        int        decay_cycles;
        int        peak;
        sa = 2 + ($unsigned($random(seed)) % 4);
        sd = 2 + ($unsigned($random(seed)) % 4);
        sr = 2 + ($unsigned($random(seed)) % 4);
        row.n_notes                 = n;
        row.enable                  = en;
        row.exp_idle                = exp_idle;
        row.exp_drops               = exp_drops;
        row.params.attack_level     = {atk_top, 16'h0000};
        row.params.sustain_level    = {sus_top, 16'h0000};
        row.params.sustain_duration = dur;
        row.params.attack_step      = row.params.attack_level >> sa;
        row.params.release_step     = row.params.sustain_level >> sr;
        // With equal levels the decay ends at once and any nonzero step will do
        if (atk_top == sus_top) begin
            row.params.decay_step = row.params.sustain_level >> sd;
            decay_cycles          = 0;
        end else begin
            row.params.decay_step =
                (row.params.attack_level - row.params.sustain_level) >> sd;
            decay_cycles          = 1 << sd;
        end
        // Several voices overlap only in sustain, since their peak equals sustain there
        nv   = (n > NUM_VOICES) ? NUM_VOICES : n;
        peak = (nv == 1) ? atk_top : nv * sus_top;
        row.exp_peak = (peak > 16'hFFFF) ? 16'hFFFF : peak;
        // Notes, attack, decay, hold and release plus slack
        cycle_limit += n + 8 + (1 << sa) + decay_cycles + dur + (1 << sr) + 50;
        rows.push_back(row);
        names.push_back(name);
    endtask

    // Applies one row and checks what the bank does with it
    task automatic run_row(input string name, input test_row_t row);
        int          nv;
        int          k;
        int          m;
        int          mid_step;
        logic [31:0] sus_mix;
        row_steps  = 0;
        row_errors = 0;
        peak_seen  = '0;
        drops_seen = 0;
        nv = (row.n_notes > NUM_VOICES) ? NUM_VOICES : row.n_notes;
        k  = row.params.attack_level / row.params.attack_step;
        m  = (row.params.attack_level - row.params.sustain_level) / row.params.decay_step;
        sus_mix = nv * row.params.sustain_level[ACC_W-1 -: ENV_W];
        if (sus_mix > 32'hFFFF) begin
            sus_mix = 32'hFFFF;
        end

        // Back-to-back strobes that are each sampled on their own edge
        note_i.params = row.params;
        note_valid_i  = 1'b1;
        repeat (row.n_notes) step_cycle();
        note_valid_i = 1'b0;

        // Two edges after the last strobe the chosen voice has left IDLE
        repeat (2) step_cycle();
        check_value("voices_idle_o", voices_idle_o, row.exp_idle);

        // Midpoint of the first voice's hold as seen through the one-edge lag of the mix
        mid_step = 5 + k + m + row.params.sustain_duration / 2;
        while (row_steps < mid_step) step_cycle();
        check_value("mix_o at sustain", mix_o, sus_mix);

        if (!row.enable) begin
            enable_i = 1'b0;
            repeat (2) step_cycle();
            check_value("voices_idle_o after disable", voices_idle_o, {NUM_VOICES{1'b1}});
        end

        while (!all_idle_o) step_cycle();
        step_cycle();

        // A forced stop keeps the accumulator, so the mix stays at the hold level
        if (row.enable) begin
            check_value("mix_o after release", mix_o, 32'h0);
        end else begin
            check_value("mix_o after disable", mix_o, sus_mix);
        end
        check_value("mix_o peak", peak_seen, row.exp_peak);
        check_value("note_dropped_o count", drops_seen, row.exp_drops);

        if (row_errors == 0) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d errors", name, row_errors);
        end
    endtask

    initial begin
        arst_n_i     = 1'b0;
        enable_i     = 1'b1;
        note_valid_i = 1'b0;
        note_i       = '0;

        add_row("single", 1, 16'h8000, 16'h4000, 12, 1'b1, 4'b1110, 0);
        add_row("allocation", 3, 16'h3000, 16'h3000, 16, 1'b1, 4'b1000, 0);
        add_row("overflow", 5, 16'h2000, 16'h2000, 20, 1'b1, 4'b0000, 1);
        add_row("saturation", 4, 16'hC000, 16'hC000, 16, 1'b1, 4'b0000, 0);
        // Disable leaves stale accumulators behind, so this row runs last
        add_row("enable", 1, 16'h6000, 16'h5000, 16, 1'b0, 4'b1110, 0);

        repeat (4) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Idle bank straight out of reset
        row_errors = 0;
        check_value("voices_idle_o", voices_idle_o, {NUM_VOICES{1'b1}});
        check_value("all_idle_o", all_idle_o, 1'b1);
        check_value("mix_o", mix_o, 32'h0);
        check_value("note_dropped_o", note_dropped_o, 1'b0);
        if (row_errors == 0) begin
            pass_count++;
            $display("test reset: pass");
        end else begin
            fail_count++;
            $display("test reset: fail with %0d errors", row_errors);
        end

        foreach (rows[i]) begin
            run_row(names[i], rows[i]);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_envelope_bank

// File: sim.f
bank_cfg_pkg.sv
envelope_pkg.sv
adsr_envelope.sv
voice_dispatcher.sv
envelope_mixer.sv
envelope_bank_top.sv
tb_envelope_bank.sv
